// ==== design/load_store_queue.sv ====
// Circular load/store queue with head/tail pointers and occupancy count
// Bypasses a push straight to the output when empty and read at once
`include "lsu_cfg.svh"

module load_store_queue import lsu_pkg::*; (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  lsq_interface_t instruction_i,    // Push, valid is the strobe
    input  logic           flush_i,          // Drops every queued entry
    input  logic           read_head_i,      // Pop request from the sequencer
    output lsq_interface_t instruction_o,    // Popped entry, one cycle after read
    output lsq_entry_t     ls_queue_entry_o, // Registered tail slot
    output logic           full_o,
    output logic           empty_o
);

    // Control part of a stored entry
    typedef struct packed {
        ls_type_e   instr_type;
        mem_size_e  funct3;
        logic [4:0] rd;
    } ctrl_cell_t;

    ctrl_cell_t ctrl_mem [`LSU_NUM_ENTRIES];
    xlen_t      addr_mem [`LSU_NUM_ENTRIES];
    xlen_t      data_mem [`LSU_NUM_ENTRIES];

    lsq_entry_t head_q;
    lsq_entry_t tail_q;
    logic [$clog2(`LSU_NUM_ENTRIES):0] count_q; // One bit wider than the pointers
    logic       init_done_q;                    // Low in reset and the cycle after

    logic       write_en;
    logic       bypass;
    logic       push_en;
    logic       read_en;

    logic       out_valid_q;
    ctrl_cell_t out_ctrl_q;
    xlen_t      out_addr_q;
    xlen_t      out_data_q;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == `LSU_NUM_ENTRIES) | flush_i | ~init_done_q;

    assign write_en = instruction_i.valid & ~full_o;          // Push while full is dropped
    assign bypass   = read_head_i & ~flush_i & empty_o & write_en;
    assign push_en  = write_en & ~bypass;                     // Entry takes a slot
    assign read_en  = read_head_i & ~flush_i & ~empty_o;

    assign instruction_o = '{valid:      out_valid_q,
                             instr_type: out_ctrl_q.instr_type,
                             funct3:     out_ctrl_q.funct3,
                             rd:         out_ctrl_q.rd,
                             addr:       out_addr_q,
                             data:       out_data_q};

    // Storage and output payload
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            ctrl_mem[tail_q] <= '{instruction_i.instr_type, instruction_i.funct3,
                                  instruction_i.rd};
            addr_mem[tail_q] <= instruction_i.addr;
            data_mem[tail_q] <= instruction_i.data;
        end
        if (bypass) begin                       // Empty queue, hand the push over directly
            out_ctrl_q <= '{instruction_i.instr_type, instruction_i.funct3,
                            instruction_i.rd};
            out_addr_q <= instruction_i.addr;
            out_data_q <= instruction_i.data;
        end else if (read_en) begin
            out_ctrl_q <= ctrl_mem[head_q];
            out_addr_q <= addr_mem[head_q];
            out_data_q <= data_mem[head_q];
        end
    end

    // Pointers and count
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q           <= '0;
            tail_q           <= '0;
            count_q          <= '0;
            ls_queue_entry_o <= '0;
            out_valid_q      <= 1'b0;
            init_done_q      <= 1'b0;
        end else begin
            init_done_q <= 1'b1;
            out_valid_q <= read_en | bypass;
            if (flush_i) begin
                head_q           <= '0;
                tail_q           <= '0;
                count_q          <= '0;
                ls_queue_entry_o <= '0;
            end else begin
                ls_queue_entry_o <= tail_q;
                if (push_en) tail_q <= tail_q + 1'b1;   // Wraps, depth is a power of two
                if (read_en) head_q <= head_q + 1'b1;
                case ({push_en, read_en})
                    2'b10:   count_q <= count_q + 1'b1;
                    2'b01:   count_q <= count_q - 1'b1;
                    default: count_q <= count_q;
                endcase
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_q <= `LSU_NUM_ENTRIES)
        else $error("LSQ count above depth");

    // Sequencer only reads an empty queue when a bypass push is present
    a_no_empty_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (read_head_i & empty_o & ~flush_i) |-> instruction_i.valid)
        else $error("LSQ read while empty");

endmodule

// ==== design/lsu_cfg.svh ====
// Build-time sizing of the load/store unit
// Queue depth, datapath width and memory response timeout
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Entries in the load/store queue, must be a power of two
`define LSU_NUM_ENTRIES 8

// Address and data width, the byte-lane logic assumes 64
`define LSU_XLEN 64

// Wait cycles before an outstanding access is declared a fault
`define LSU_MEM_TIMEOUT 16

`endif

// ==== design/lsu_data_align.sv ====
// Byte-lane alignment of store data and extraction/extension of load data
// Also flags accesses not aligned to their size
`include "lsu_cfg.svh"

module lsu_data_align import lsu_pkg::*; (
    input  mem_size_e  funct3_i,
    input  xlen_t      addr_i,
    input  xlen_t      store_data_i,
    input  xlen_t      load_raw_i,     // Full doubleword from memory
    output logic [7:0] byte_mask_o,
    output xlen_t      store_data_o,
    output xlen_t      load_data_o,
    output logic       misaligned_o
);

    logic [2:0] offset;
    logic [5:0] bit_shift;
    xlen_t      load_shifted;

    assign offset    = addr_i[2:0];
    assign bit_shift = {offset, 3'b000};               // Byte offset in bits

    assign store_data_o = store_data_i << bit_shift;
    assign load_shifted = load_raw_i >> bit_shift;     // Addressed field to bit 0

    always_comb begin
        case (funct3_i)
            LB, LBU: begin
                byte_mask_o  = 8'h01 << offset;
                misaligned_o = 1'b0;
            end
            LH, LHU: begin
                byte_mask_o  = 8'h03 << offset;
                misaligned_o = offset[0];
            end
            LW, LWU: begin
                byte_mask_o  = 8'h0f << offset;
                misaligned_o = |offset[1:0];
            end
            LD: begin
                byte_mask_o  = 8'hff;
                misaligned_o = |offset;
            end
            default: begin                             // Unused code, treat as byte
                byte_mask_o  = 8'h01 << offset;
                misaligned_o = 1'b0;
            end
        endcase
    end

    // Sign extend LB/LH/LW, zero extend the rest
    always_comb begin
        case (funct3_i)
            LB:      load_data_o = {{(`LSU_XLEN-8){load_shifted[7]}}, load_shifted[7:0]};
            LH:      load_data_o = {{(`LSU_XLEN-16){load_shifted[15]}}, load_shifted[15:0]};
            LW:      load_data_o = {{(`LSU_XLEN-32){load_shifted[31]}}, load_shifted[31:0]};
            LBU:     load_data_o = {{(`LSU_XLEN-8){1'b0}}, load_shifted[7:0]};
            LHU:     load_data_o = {{(`LSU_XLEN-16){1'b0}}, load_shifted[15:0]};
            LWU:     load_data_o = {{(`LSU_XLEN-32){1'b0}}, load_shifted[31:0]};
            default: load_data_o = load_shifted;       // LD
        endcase
    end

endmodule

// ==== design/lsu_mem_fsm.sv ====
// Sequencer popping the queue and running one memory access at a time
// Forms the memory request and the writeback result
`include "lsu_cfg.svh"

module lsu_mem_fsm import lsu_pkg::*; (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           empty_i,
    output logic           read_head_o,
    input  lsq_interface_t entry_i,         // Popped entry, valid one cycle after read
    output mem_req_t       mem_req_o,
    input  mem_resp_t      mem_resp_i,
    input  logic           timeout_i,
    output logic           timer_start_o,
    output logic           timer_stop_o,
    output lsu_result_t    result_o
);

    fsm_state_e     state_q, state_d;
    lsq_interface_t entry_q;                // Operation in flight
    xlen_t          res_data_q;
    logic           fault_q;

    logic [7:0]     byte_mask;
    xlen_t          store_data;
    xlen_t          load_data;
    logic           misaligned;
    logic           is_store;

    assign is_store = (entry_q.instr_type == LS_STORE);

    lsu_data_align data_align_i (
        .funct3_i     (entry_q.funct3),
        .addr_i       (entry_q.addr),
        .store_data_i (entry_q.data),
        .load_raw_i   (mem_resp_i.rdata),
        .byte_mask_o  (byte_mask),
        .store_data_o (store_data),
        .load_data_o  (load_data),
        .misaligned_o (misaligned)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (!empty_i) state_d = POP;
            POP:     state_d = entry_i.valid ? ISSUE : IDLE;    // Nothing arrives after a flush
            ISSUE:   state_d = misaligned ? DONE : WAIT;
            WAIT:    if (mem_resp_i.valid || timeout_i) state_d = DONE;
            default: state_d = IDLE;                            // DONE
        endcase
    end

    assign read_head_o   = (state_q == IDLE) & ~empty_i;
    assign timer_start_o = mem_req_o.valid;
    assign timer_stop_o  = (state_q == WAIT) & (mem_resp_i.valid | timeout_i);

    always_comb begin
        mem_req_o.valid     = (state_q == ISSUE) & ~misaligned;
        mem_req_o.write     = is_store;
        mem_req_o.addr      = {entry_q.addr[`LSU_XLEN-1:3], 3'b000};
        mem_req_o.byte_mask = byte_mask;
        mem_req_o.wdata     = store_data;
        result_o.valid      = (state_q == DONE);
        result_o.is_store   = is_store;
        result_o.rd         = entry_q.rd;
        result_o.data       = res_data_q;
        result_o.fault      = fault_q;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) state_q <= IDLE;
        else         state_q <= state_d;
    end

    // Held entry and result payload
    always_ff @(posedge clk_i) begin
        if (state_q == POP && entry_i.valid) entry_q <= entry_i;
        if (state_q == ISSUE && misaligned) begin
            fault_q    <= 1'b1;
            res_data_q <= '0;
        end
        if (state_q == WAIT) begin
            if (mem_resp_i.valid) begin           // Response wins over a same-cycle timeout
                fault_q    <= 1'b0;
                res_data_q <= is_store ? '0 : load_data;
            end else if (timeout_i) begin
                fault_q    <= 1'b1;
                res_data_q <= '0;
            end
        end
    end

    a_one_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_o.valid |=> (!mem_req_o.valid throughout result_o.valid [->1]))
        else $error("Second memory request before result");

    // Clean result follows a response, a faulting one a timeout or a misaligned entry
    a_result_cause: assert property (@(posedge clk_i) disable iff (!rstn_i)
        result_o.valid |-> (result_o.fault
                            ? $past(timeout_i || (state_q == ISSUE && misaligned))
                            : $past(mem_resp_i.valid)))
        else $error("Result without a matching response, timeout or misalignment");

endmodule

// ==== design/lsu_pkg.sv ====
// Shared types of the load/store unit
// Operation enums, queue entry, memory request/response and writeback structs
`include "lsu_cfg.svh"

package lsu_pkg;

    // Kind of memory instruction
    typedef enum logic {
        LS_LOAD  = 1'b0,
        LS_STORE = 1'b1
    } ls_type_e;

    // RISC-V funct3 encodings of the access size
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } mem_size_e;

    // Memory sequencer states
    typedef enum logic [2:0] {
        IDLE,
        POP,
        ISSUE,
        WAIT,
        DONE
    } fsm_state_e;

    typedef logic [$clog2(`LSU_NUM_ENTRIES)-1:0] lsq_entry_t;   // Queue slot index
    typedef logic [`LSU_XLEN-1:0]                xlen_t;

    // Decoded memory instruction, valid doubles as the push strobe
    typedef struct packed {
        logic      valid;
        ls_type_e  instr_type;
        mem_size_e funct3;
        logic [4:0] rd;
        xlen_t     addr;
        xlen_t     data;        // Store data, unused for loads
    } lsq_interface_t;

    typedef struct packed {
        logic       valid;      // One-cycle request strobe
        logic       write;
        xlen_t      addr;       // Doubleword aligned
        logic [7:0] byte_mask;
        xlen_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;           // One-cycle response strobe
        xlen_t rdata;
    } mem_resp_t;

    // Writeback to the core
    typedef struct packed {
        logic       valid;
        logic       is_store;
        logic [4:0] rd;
        xlen_t      data;       // Zero for stores and faults
        logic       fault;
    } lsu_result_t;

endpackage

// ==== design/lsu_top.sv ====
// Load/store unit top level
// Queue, memory sequencer and response timer
module lsu_top import lsu_pkg::*; (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  lsq_interface_t instruction_i,    // From decode
    input  logic           flush_i,
    output mem_req_t       mem_req_o,
    input  mem_resp_t      mem_resp_i,
    output lsu_result_t    result_o,         // Writeback to the core
    output logic           full_o,
    output lsq_entry_t     ls_queue_entry_o
);

    logic           read_head;
    logic           empty;
    lsq_interface_t head_entry;             // Queue output to the sequencer
    logic           timer_start;
    logic           timer_stop;
    logic           timeout;

    load_store_queue queue_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .instruction_i    (instruction_i),
        .flush_i          (flush_i),
        .read_head_i      (read_head),
        .instruction_o    (head_entry),
        .ls_queue_entry_o (ls_queue_entry_o),
        .full_o           (full_o),
        .empty_o          (empty)
    );

    lsu_mem_fsm mem_fsm_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .empty_i       (empty),
        .read_head_o   (read_head),
        .entry_i       (head_entry),
        .mem_req_o     (mem_req_o),
        .mem_resp_i    (mem_resp_i),
        .timeout_i     (timeout),
        .timer_start_o (timer_start),
        .timer_stop_o  (timer_stop),
        .result_o      (result_o)
    );

    mem_wait_timer wait_timer_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .start_i   (timer_start),
        .stop_i    (timer_stop),
        .timeout_o (timeout)
    );

endmodule

// ==== design/mem_wait_timer.sv ====
// Memory response wait counter with a single timeout strobe
`include "lsu_cfg.svh"

module mem_wait_timer (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic start_i,       // Request issued
    input  logic stop_i,        // Response seen or operation closed
    output logic timeout_o      // One-cycle strobe at the limit
);

    localparam int unsigned cnt_w = $clog2(`LSU_MEM_TIMEOUT + 1);

    logic             running_q;
    logic [cnt_w-1:0] cnt_q;
    logic             timeout_q;

    assign timeout_o = timeout_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            running_q <= 1'b0;
            cnt_q     <= '0;
            timeout_q <= 1'b0;
        end else begin
            timeout_q <= 1'b0;
            if (start_i) begin
                running_q <= 1'b1;
                cnt_q     <= '0;
            end else if (running_q) begin
                if (stop_i) begin
                    running_q <= 1'b0;
                end else if (cnt_q != cnt_w'(`LSU_MEM_TIMEOUT)) begin  // Saturates
                    cnt_q     <= cnt_q + 1'b1;
                    timeout_q <= (cnt_q == cnt_w'(`LSU_MEM_TIMEOUT - 1));
                end
            end
        end
    end

    a_no_restart: assert property (@(posedge clk_i) disable iff (!rstn_i)
        start_i |-> !running_q)
        else $error("Timer started while already running");

    a_stop_running: assert property (@(posedge clk_i) disable iff (!rstn_i)
        stop_i |-> running_q)
        else $error("Timer stopped while idle");

endmodule

// ==== lsu_top.f ====
+incdir+design
design/lsu_pkg.sv
design/load_store_queue.sv
design/mem_wait_timer.sv
design/lsu_data_align.sv
design/lsu_mem_fsm.sv
design/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator, run from the project root

LOG=sim.log
BIN=obj_dir/lsu_sim

verilator --binary --timing --assert -j 0 --top-module lsu_top_tb -f lsu_top.f -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./$BIN > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== tests/lsu_checker.sv ====
// Watches memory requests, writebacks and the queue tail slot
// Compares them with the vector table and a tail pointer model
`include "lsu_cfg.svh"

module lsu_checker import lsu_pkg::*; #(
    parameter int MAX_VEC = 64
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  mem_req_t    mem_req_i,
    input  lsu_result_t result_i,
    input  logic        push_i,                // Push strobe into the DUT
    input  logic        full_i,
    input  logic        flush_i,
    input  lsq_entry_t  tail_i,                // Registered tail slot of the queue
    input  int          num_vec_i,
    input  logic        op_i     [MAX_VEC],    // 1 for store
    input  logic [4:0]  rd_i     [MAX_VEC],
    input  logic [63:0] addr_i   [MAX_VEC],
    input  logic [7:0]  mask_i   [MAX_VEC],    // Zero when no request is expected
    input  logic [63:0] wdata_i  [MAX_VEC],
    input  logic [63:0] data_i   [MAX_VEC],
    input  logic        fault_i  [MAX_VEC],
    input  logic        killed_i [MAX_VEC],    // Flushed before issue
    output int          errors_o,
    output int          reqs_o,
    output int          results_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int         req_idx;
    int         res_idx;
    lsq_entry_t exp_tail;                      // Tail pointer model
    lsq_entry_t exp_slot;                      // Expected registered tail

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp_v, act_v);
            errors_o++;
        end
    endtask

    // Sampled mid-cycle where DUT outputs are settled
    always @(negedge clk_i) begin
        if (!rstn_i) begin
            req_idx   = 0;
            res_idx   = 0;
            errors_o  = 0;
            reqs_o    = 0;
            results_o = 0;
            exp_tail  = '0;
            exp_slot  = '0;
        end else begin
            if (mem_req_i.valid) begin
                while (req_idx < num_vec_i && (killed_i[req_idx] || mask_i[req_idx] == 8'h00))
                    req_idx++;
                if (req_idx >= num_vec_i) begin
                    $display("Unexpected memory request to address %h", mem_req_i.addr);
                    errors_o++;
                end else begin
                    check_value($sformatf("vec%0d write", req_idx), 64'(op_i[req_idx]),
                                64'(mem_req_i.write));
                    check_value($sformatf("vec%0d addr", req_idx),
                                addr_i[req_idx] & ~64'h7, mem_req_i.addr);   // 8-byte aligned
                    check_value($sformatf("vec%0d mask", req_idx), 64'(mask_i[req_idx]),
                                64'(mem_req_i.byte_mask));
                    if (op_i[req_idx])
                        check_value($sformatf("vec%0d wdata", req_idx), wdata_i[req_idx],
                                    mem_req_i.wdata);
                    req_idx++;
                    reqs_o++;
                end
            end
            if (result_i.valid) begin
                while (res_idx < num_vec_i && killed_i[res_idx]) res_idx++;   // Never complete
                if (res_idx >= num_vec_i) begin
                    $display("Unexpected result for rd %0d", result_i.rd);
                    errors_o++;
                end else begin
                    check_value($sformatf("vec%0d is_store", res_idx), 64'(op_i[res_idx]),
                                64'(result_i.is_store));
                    check_value($sformatf("vec%0d rd", res_idx), 64'(rd_i[res_idx]),
                                64'(result_i.rd));
                    check_value($sformatf("vec%0d data", res_idx), data_i[res_idx],
                                result_i.data);
                    check_value($sformatf("vec%0d fault", res_idx), 64'(fault_i[res_idx]),
                                64'(result_i.fault));
                    res_idx++;
                    results_o++;
                end
            end
            // Registered tail lags the pointer by one cycle
            check_value("tail slot", 64'(exp_slot), 64'(tail_i));
            if (flush_i) begin                 // Flush clears both
                exp_tail = '0;
                exp_slot = '0;
            end else begin
                exp_slot = exp_tail;
                if (push_i && !full_i) exp_tail = exp_tail + 1'b1;    // Wraps at depth
            end
        end
    end

endmodule

// ==== tests/lsu_top_tb.sv ====
// LSU testbench top: clock, reset, vector reader, stimulus, memory model and watchdog
`include "lsu_cfg.svh"

module lsu_top_tb import lsu_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC = 64;

    logic           clk_i;
    logic           rstn_i;
    lsq_interface_t instruction;
    logic           flush;
    mem_req_t       mem_req;
    mem_resp_t      mem_resp;
    lsu_result_t    result;
    logic           full;
    lsq_entry_t     tail_slot;

    // Vector table, one slot per file line
    logic        v_op     [MAX_VEC];
    logic [2:0]  v_f3     [MAX_VEC];
    logic [4:0]  v_rd     [MAX_VEC];
    logic [63:0] v_addr   [MAX_VEC];
    logic [63:0] v_sdata  [MAX_VEC];
    logic [63:0] v_rdata  [MAX_VEC];
    int          v_delay  [MAX_VEC];   // Response delay in cycles
    logic [7:0]  v_mask   [MAX_VEC];   // Zero means no request expected
    logic [63:0] v_wdata  [MAX_VEC];
    logic [63:0] v_data   [MAX_VEC];
    logic        v_fault  [MAX_VEC];
    int          v_mode   [MAX_VEC];   // 0 gap, 1 drain first, 2 flushed, 3 back to back
    logic        v_killed [MAX_VEC];

    int   num_vec;
    int   tb_errors;
    int   chk_errors;
    int   reqs_checked;
    int   results_checked;
    logic loaded;

    lsu_top lsu_top_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .instruction_i    (instruction),
        .flush_i          (flush),
        .mem_req_o        (mem_req),
        .mem_resp_i       (mem_resp),
        .result_o         (result),
        .full_o           (full),
        .ls_queue_entry_o (tail_slot)
    );

    lsu_checker #(.MAX_VEC(MAX_VEC)) checker_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .mem_req_i (mem_req),
        .result_i  (result),
        .push_i    (instruction.valid),
        .full_i    (full),
        .flush_i   (flush),
        .tail_i    (tail_slot),
        .num_vec_i (num_vec),
        .op_i      (v_op),
        .rd_i      (v_rd),
        .addr_i    (v_addr),
        .mask_i    (v_mask),
        .wdata_i   (v_wdata),
        .data_i    (v_data),
        .fault_i   (v_fault),
        .killed_i  (v_killed),
        .errors_o  (chk_errors),
        .reqs_o    (reqs_checked),
        .results_o (results_checked)
    );

    always #10 clk_i = ~clk_i;              // 20 ns period

    task automatic read_vectors();
        int          fd;
        int          n;
        int          dly;
        int          mode;
        string       line;
        logic [63:0] op, f3, rd, addr, sdata, rdata, mask, wdata, data, fault;
        fd = $fopen("tests/lsu_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open vector file");
            tb_errors++;
            return;
        end
        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;   // Comment or blank
            n = $sscanf(line, "%h %h %h %h %h %h %d %h %h %h %h %d", op, f3, rd, addr,
                        sdata, rdata, dly, mask, wdata, data, fault, mode);
            if (n != 12 || num_vec >= MAX_VEC) continue;
            v_op[num_vec]     = op[0];
            v_f3[num_vec]     = f3[2:0];
            v_rd[num_vec]     = rd[4:0];
            v_addr[num_vec]   = addr;
            v_sdata[num_vec]  = sdata;
            v_rdata[num_vec]  = rdata;
            v_delay[num_vec]  = dly;
            v_mask[num_vec]   = mask[7:0];
            v_wdata[num_vec]  = wdata;
            v_data[num_vec]   = data;
            v_fault[num_vec]  = fault[0];
            v_mode[num_vec]   = mode;
            v_killed[num_vec] = (mode == 2);
            num_vec++;
        end
        $fclose(fd);
    endtask

    // Called 2 ns after an edge, returns 2 ns after an edge
    task automatic wait_results(input int n);
        while (results_checked < n) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic push_op(input int i);
        while (full) begin                  // No push while the queue is full
            @(posedge clk_i);
            #2;
        end
        instruction.valid      = 1'b1;
        instruction.instr_type = ls_type_e'(v_op[i]);
        instruction.funct3     = mem_size_e'(v_f3[i]);
        instruction.rd         = v_rd[i];
        instruction.addr       = v_addr[i];
        instruction.data       = v_sdata[i];
        @(posedge clk_i);
        #2;
        instruction.valid = 1'b0;
    endtask

    initial begin : stimulus
        int seed_val;
        int gap;
        int burst_pushed;
        int live_pushed;
        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        instruction  = '0;
        flush        = 1'b0;
        tb_errors    = 0;
        num_vec      = 0;
        loaded       = 1'b0;
        burst_pushed = 0;
        live_pushed  = 0;
        seed_val     = $urandom(32'h9b85b050);
        for (int k = 0; k < MAX_VEC; k++) v_killed[k] = 1'b0;
        read_vectors();
        if (num_vec == 0) begin
            $display("No vectors were loaded");
            tb_errors++;
        end
        repeat (10) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;
        loaded = 1'b1;
        for (int i = 0; i < num_vec; i++) begin
            if (v_mode[i] == 1) begin
                wait_results(live_pushed);  // Pipeline empty before this op
            end else if (v_mode[i] == 0) begin
                gap = int'($urandom % 4);
                repeat (gap) @(posedge clk_i);
                if (gap > 0) #2;
            end
            if (v_mode[i] == 3) begin     // Full must rise exactly at depth
                if (burst_pushed == `LSU_NUM_ENTRIES + 1 && !full) begin
                    $display("CHECK FAILED full_o at depth: expected 1, actual 0");
                    tb_errors++;
                end else if (burst_pushed < `LSU_NUM_ENTRIES + 1 && full) begin
                    $display("CHECK FAILED full_o below depth: expected 0, actual 1");
                    tb_errors++;
                end
            end
            push_op(i);
            burst_pushed = (v_mode[i] == 1) ? 1 : (v_mode[i] == 3) ? burst_pushed + 1 : 0;
            if (!v_killed[i]) live_pushed++;
            if (v_mode[i] == 2 && (i + 1 >= num_vec || v_mode[i+1] != 2)) begin
                flush = 1'b1;               // Drop the queued group
                @(posedge clk_i);
                #2;
                flush = 1'b0;
            end
        end
        wait_results(live_pushed);
        repeat (30) @(posedge clk_i);       // Catch late or extra results
        $display("Errors: %0d checker, %0d stimulus; %0d requests, %0d results checked",
                 chk_errors, tb_errors, reqs_checked, results_checked);
        if (chk_errors + tb_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Memory model, answers each request after the vector's delay
    initial begin : memory_model
        int idx;
        idx      = 0;
        mem_resp = '0;
        wait (loaded);
        forever begin
            @(negedge clk_i);
            if (mem_req.valid) begin
                while (idx < num_vec && (v_killed[idx] || v_mask[idx] == 8'h00)) idx++;
                if (idx < num_vec && v_delay[idx] <= `LSU_MEM_TIMEOUT) begin
                    repeat (v_delay[idx] + 1) @(posedge clk_i);
                    #2;
                    mem_resp.valid = 1'b1;
                    mem_resp.rdata = v_rdata[idx];
                    @(posedge clk_i);
                    #2;
                    mem_resp.valid = 1'b0;
                end                         // Longer delays are never answered
                idx++;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (num_vec * (`LSU_MEM_TIMEOUT + 40)) @(posedge clk_i);
        $display("Watchdog expired before all operations completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== tests/lsu_vectors.txt ====
# op(1=store) funct3 rd addr sdata rdata delay | exp: mask wdata data fault | mode
# mode 0 random gap, 1 wait for drain, 2 flushed while queued, 3 back to back
1 0 01 1003 1122334455667788 0 2 08 4455667788000000 0 0 0
1 1 02 2006 AAAABBBBCCCCDDDD 0 0 C0 DDDD000000000000 0 0 0
1 2 03 3004 00000000DEADBEEF 0 5 F0 DEADBEEF00000000 0 0 0
1 3 04 4000 0123456789ABCDEF 0 1 FF 0123456789ABCDEF 0 0 0
0 0 05 5005 0 8899AABBCCDDEEFF 1 20 0 FFFFFFFFFFFFFFAA 0 0
0 4 06 5005 0 8899AABBCCDDEEFF 3 20 0 00000000000000AA 0 0
0 1 07 5002 0 8899AABBCCDDEEFF 0 0C 0 FFFFFFFFFFFFCCDD 0 0
0 5 08 5006 0 8899AABBCCDDEEFF 2 C0 0 0000000000008899 0 0
0 2 09 5004 0 8899AABBCCDDEEFF 4 F0 0 FFFFFFFF8899AABB 0 0
0 6 0A 5000 0 8899AABBCCDDEEFF 1 0F 0 00000000CCDDEEFF 0 0
0 3 0B 5008 0 8899AABBCCDDEEFF 6 FF 0 8899AABBCCDDEEFF 0 0
0 2 0C 6000 0 123456787FFFFFFF 2 0F 0 000000007FFFFFFF 0 0
0 1 0D 6000 0 0000000000007123 0 03 0 0000000000007123 0 0
0 1 0E 7001 0 0 0 00 0 0 1 0
1 2 0F 7002 CAFEF00D 0 0 00 0 0 1 0
0 3 10 7004 0 0 0 00 0 0 1 0
0 2 11 8000 0 FFFFFFFF 99 0F 0 0 1 0
0 3 12 8008 0 0F0E0D0C0B0A0908 3 FF 0 0F0E0D0C0B0A0908 0 0
0 3 13 9000 0 1111111111111111 14 FF 0 1111111111111111 0 1
0 4 14 9000 0 8807060504030201 1 01 0 0000000000000001 0 3
0 4 15 9001 0 8807060504030201 1 02 0 0000000000000002 0 3
0 4 16 9002 0 8807060504030201 1 04 0 0000000000000003 0 3
0 4 17 9003 0 8807060504030201 1 08 0 0000000000000004 0 3
0 4 18 9004 0 8807060504030201 1 10 0 0000000000000005 0 3
0 4 19 9005 0 8807060504030201 1 20 0 0000000000000006 0 3
0 4 1A 9006 0 8807060504030201 1 40 0 0000000000000007 0 3
0 4 1B 9007 0 8807060504030201 1 80 0 0000000000000088 0 3
0 0 1C 9017 0 8807060504030201 1 80 0 FFFFFFFFFFFFFF88 0 3
0 2 1D A000 0 00000000FFFFFFFE 10 0F 0 FFFFFFFFFFFFFFFE 0 1
1 3 1E A008 5555 0 0 FF 5555 0 0 2
0 0 1F A010 0 0 0 01 0 0 0 2
1 0 00 A011 66 0 0 02 6600 0 0 2
0 4 01 B003 0 0000000077000000 2 08 0 0000000000000077 0 1
